// File: design/rx_cfg.svh
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// ----------------------------------------------------------------------
// receive chain widths
// ----------------------------------------------------------------------

// signed samples from the ADC
`define RX_ADC_WIDTH        12
// signed local oscillator table word, peak 2047
`define RX_LO_WIDTH         12
// top bits of the full 24 bit product that are kept
`define RX_MIX_WIDTH        16
// phase accumulator, one LSB is 2^-24 of a cycle
`define RX_PHASE_WIDTH      24
// full cycle cosine table, 64 entries
`define RX_TABLE_BITS       6

// ----------------------------------------------------------------------
// decimation
// ----------------------------------------------------------------------

// 5 * 8 = 40 ADC strobes per output
`define RX_CIC1_DECIM       5
`define RX_CIC2_DECIM       8
`define RX_CIC_STAGES       3
`define RX_CIC1_OUT_WIDTH   18
`define RX_OUT_WIDTH        16

`endif

// File: design/rx_pkg.sv
`include "rx_cfg.svh"

package rx_pkg;

  // ----------------------------------------------------------------------
  // sample types along the chain
  // ----------------------------------------------------------------------

  // raw ADC sample
  typedef logic signed [`RX_ADC_WIDTH-1:0] adc_sample_t;

  // mixer output, feeds the first decimator
  typedef logic signed [`RX_MIX_WIDTH-1:0] mix_sample_t;

  // first decimator output, feeds the second
  typedef logic signed [`RX_CIC1_OUT_WIDTH-1:0] mid_sample_t;

  // final baseband output
  typedef logic signed [`RX_OUT_WIDTH-1:0] out_sample_t;

  // ----------------------------------------------------------------------
  // oscillator types
  // ----------------------------------------------------------------------

  // phase accumulator and tune word, unsigned
  typedef logic [`RX_PHASE_WIDTH-1:0] phase_t;

  // cosine table word and the table itself
  typedef logic signed [`RX_LO_WIDTH-1:0] lo_word_t;
  typedef lo_word_t lo_table_t [0:(1 << `RX_TABLE_BITS)-1];
  typedef logic [`RX_TABLE_BITS-1:0] table_addr_t;

  // full precision adc x lo product
  typedef logic signed [`RX_ADC_WIDTH+`RX_LO_WIDTH-1:0] product_t;

endpackage

// File: design/iq_if.sv
`timescale 1ns/100ps

// one complex sample per strobe, no back-pressure
interface iq_if #(
  parameter type sample_t = logic
) ();

  // one cycle pulse for a new sample
  logic    strobe;
  // in-phase and quadrature parts
  sample_t i_data;
  sample_t q_data;
  // first sample after a retune, only valid with strobe
  logic    frame;

  // producer side
  modport source (
    output strobe,
    output i_data,
    output q_data,
    output frame
  );

  // consumer side
  modport sink (
    input strobe,
    input i_data,
    input q_data,
    input frame
  );

endinterface

// File: design/nco_mixer.sv
`timescale 1ns/100ps
`include "rx_cfg.svh"

module nco_mixer (
  input  logic                clock,
  input  logic                rst,
  input  logic                adc_strobe,
  input  rx_pkg::adc_sample_t adc_data,
  input  rx_pkg::phase_t      tune_word,
  input  logic                tune_load,
  iq_if.source                mix
);
  import rx_pkg::*;

  localparam int TABLE_SIZE = 1 << `RX_TABLE_BITS;
  // sine lags cosine by a quarter of the table
  localparam int QUARTER    = TABLE_SIZE / 4;
  localparam int LO_AMPL    = (1 << (`RX_LO_WIDTH - 1)) - 1;
  localparam int PROD_WIDTH = `RX_ADC_WIDTH + `RX_LO_WIDTH;

  // ----------------------------------------------------------------------
  // cosine table, built at elaboration
  // ----------------------------------------------------------------------

  // entry k = cos(2*pi*k/64) * 2047, rounded to nearest
  function automatic lo_table_t make_cos_table();
    lo_table_t tbl;
    real       angle;
    real       val;
    for (int k = 0; k < TABLE_SIZE; k++)
    begin
      angle = 2.0 * 3.14159265358979 * k / TABLE_SIZE;
      val = $cos(angle) * LO_AMPL;
      // symmetric rounding, halves go away from zero
      if (val >= 0.0)
        tbl[k] = lo_word_t'($rtoi(val + 0.5));
      else
        tbl[k] = lo_word_t'(-$rtoi(0.5 - val));
    end
    return tbl;
  endfunction

  localparam lo_table_t COS_TABLE = make_cos_table();

  // ----------------------------------------------------------------------
  // phase accumulator
  // ----------------------------------------------------------------------

  phase_t      phase;
  phase_t      tune;
  logic        pending_frame;
  table_addr_t cos_addr;
  table_addr_t sin_addr;
  lo_word_t    cos_val;
  lo_word_t    sin_val;
  product_t    prod_i;
  product_t    prod_q;

  // a load wins over a strobe in the same cycle
  // that sample still uses the old phase, the next one is framed
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      phase         <= '0;
      tune          <= '0;
      pending_frame <= 1'b0;
    end
    else if (tune_load)
    begin
      phase         <= '0;
      tune          <= tune_word;
      pending_frame <= 1'b1;
    end
    else if (adc_strobe)
    begin
      // advance only after the sample has used the phase
      phase         <= phase + tune;
      pending_frame <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // complex mix
  // ----------------------------------------------------------------------

  // top table bits of the phase, sine index wraps mod 64
  assign cos_addr = phase[`RX_PHASE_WIDTH-1 -: `RX_TABLE_BITS];
  assign sin_addr = cos_addr - table_addr_t'(QUARTER);
  assign cos_val  = COS_TABLE[cos_addr];
  assign sin_val  = COS_TABLE[sin_addr];

  // signed 12 x 12 in a 24 bit context, negation cannot overflow
  assign prod_i = adc_data * cos_val;
  assign prod_q = -(adc_data * sin_val);

  // strobe and frame, one cycle behind the adc strobe
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      mix.strobe <= 1'b0;
      mix.frame  <= 1'b0;
    end
    else
    begin
      mix.strobe <= adc_strobe;
      mix.frame  <= adc_strobe & pending_frame;
    end
  end

  // keep the top 16 bits of each product
  always_ff @(posedge clock)
  begin
    if (adc_strobe)
    begin
      mix.i_data <= prod_i[PROD_WIDTH-1 -: `RX_MIX_WIDTH];
      mix.q_data <= prod_q[PROD_WIDTH-1 -: `RX_MIX_WIDTH];
    end
  end

endmodule

// File: design/cic_decimator.sv
`timescale 1ns/100ps

module cic_decimator #(
  parameter type in_t       = logic,
  parameter type out_t      = logic,
  parameter int  DECIMATION = 5,
  parameter int  STAGES     = 3
) (
  input  logic clock,
  input  logic rst,
  iq_if.sink   in_s,
  iq_if.source out_s
);

  localparam int IN_WIDTH  = $bits(in_t);
  localparam int OUT_WIDTH = $bits(out_t);
  // gain is DECIMATION**STAGES, so grow by ceil of its log2
  localparam int ACC_WIDTH = IN_WIDTH + $clog2(DECIMATION ** STAGES);
  localparam int CNT_W     = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
  // bit just below the kept output field
  localparam int ROUND_BIT = ACC_WIDTH - OUT_WIDTH - 1;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // ----------------------------------------------------------------------
  // decimation control
  // ----------------------------------------------------------------------

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] eff_count;
  logic             group_first;
  logic             group_last;
  logic             group_frame;
  // comb update request, one cycle after the last input of a group
  logic             dump;
  logic             dump_frame;

  // a framed sample always opens a new group
  assign eff_count   = in_s.frame ? '0 : count;
  assign group_first = (eff_count == '0);
  assign group_last  = (eff_count == CNT_W'(DECIMATION - 1));

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      count       <= '0;
      group_frame <= 1'b0;
      dump        <= 1'b0;
      dump_frame  <= 1'b0;
    end
    else
    begin
      dump <= in_s.strobe & group_last;
      if (in_s.strobe)
      begin
        count <= group_last ? '0 : eff_count + CNT_W'(1);
        // remember whether this group started on a retune
        if (group_first)
          group_frame <= in_s.frame;
        dump_frame <= group_first ? in_s.frame : group_frame;
      end
    end
  end

  // ----------------------------------------------------------------------
  // integrators and combs, one chain per channel
  // ----------------------------------------------------------------------

  // channel 0 is I, channel 1 is Q
  acc_t chan_in [2];
  out_t rounded [2];

  // sign extend into the accumulator width
  assign chan_in[0] = acc_t'(in_s.i_data);
  assign chan_in[1] = acc_t'(in_s.q_data);

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_chan
    acc_t integ [STAGES];
    acc_t comb  [STAGES+1];
    acc_t delay [STAGES];

    // pipelined integrators, each adds the previous stage register
    // wraparound is fine, the combs undo it
    always_ff @(posedge clock)
    begin
      if (rst)
      begin
        for (int s = 0; s < STAGES; s++)
          integ[s] <= '0;
      end
      else if (in_s.strobe)
      begin
        integ[0] <= integ[0] + chan_in[ch];
        for (int s = 1; s < STAGES; s++)
          integ[s] <= integ[s] + integ[s-1];
      end
    end

    // combinational comb differences at the low rate
    always_comb
    begin
      comb[0] = integ[STAGES-1];
      for (int s = 0; s < STAGES; s++)
        comb[s+1] = comb[s] - delay[s];
    end

    // comb delays move only on a dump
    always_ff @(posedge clock)
    begin
      if (rst)
      begin
        for (int s = 0; s < STAGES; s++)
          delay[s] <= '0;
      end
      else if (dump)
      begin
        for (int s = 0; s < STAGES; s++)
          delay[s] <= comb[s];
      end
    end

    // round half up: top bits plus the next lower bit
    assign rounded[ch] = out_t'(comb[STAGES][ACC_WIDTH-1 -: OUT_WIDTH] +
      {{(OUT_WIDTH-1){1'b0}}, comb[STAGES][ROUND_BIT]});
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  // strobe two cycles after the input that closed the group
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      out_s.strobe <= 1'b0;
      out_s.frame  <= 1'b0;
    end
    else
    begin
      out_s.strobe <= dump;
      out_s.frame  <= dump & dump_frame;
    end
  end

  always_ff @(posedge clock)
  begin
    if (dump)
    begin
      out_s.i_data <= rounded[0];
      out_s.q_data <= rounded[1];
    end
  end

endmodule

// File: design/rx_ddc.sv
`timescale 1ns/100ps
`include "rx_cfg.svh"

module rx_ddc (
  input  logic                clock,
  input  logic                rst,
  input  logic                adc_strobe,
  input  logic                tune_load,
  input  rx_pkg::adc_sample_t adc_data,
  input  rx_pkg::phase_t      tune_word,
  output logic                out_strobe,
  output logic                out_frame,
  output rx_pkg::out_sample_t out_i,
  output rx_pkg::out_sample_t out_q
);
  import rx_pkg::*;

  // ----------------------------------------------------------------------
  // links between stages
  // ----------------------------------------------------------------------

  iq_if #(.sample_t(mix_sample_t)) mix_if ();
  iq_if #(.sample_t(mid_sample_t)) mid_if ();
  iq_if #(.sample_t(out_sample_t)) out_if ();

  // mixer, 1 cycle latency
  nco_mixer u_mixer (
    .clock      (clock),
    .rst        (rst),
    .adc_strobe (adc_strobe),
    .adc_data   (adc_data),
    .tune_word  (tune_word),
    .tune_load  (tune_load),
    .mix        (mix_if.source)
  );

  // first decimator, 16 bit in, 18 bit out, 2 cycle latency
  cic_decimator #(
    .in_t       (mix_sample_t),
    .out_t      (mid_sample_t),
    .DECIMATION (`RX_CIC1_DECIM),
    .STAGES     (`RX_CIC_STAGES)
  ) u_cic1 (
    .clock (clock),
    .rst   (rst),
    .in_s  (mix_if.sink),
    .out_s (mid_if.source)
  );

  // second decimator, 18 bit in, 16 bit out
  cic_decimator #(
    .in_t       (mid_sample_t),
    .out_t      (out_sample_t),
    .DECIMATION (`RX_CIC2_DECIM),
    .STAGES     (`RX_CIC_STAGES)
  ) u_cic2 (
    .clock (clock),
    .rst   (rst),
    .in_s  (mid_if.sink),
    .out_s (out_if.source)
  );

  // 5 cycles from the closing adc strobe to here
  assign out_strobe = out_if.strobe;
  assign out_frame  = out_if.frame;
  assign out_i      = out_if.i_data;
  assign out_q      = out_if.q_data;

endmodule

// File: verif/rx_ddc_properties.sv
`timescale 1ns/100ps

// strobe checks for one cic decimator, attached by bind
module rx_ddc_properties (
  input logic clock,
  input logic rst,
  input logic in_strobe,
  input logic out_strobe
);

  // number of failed assertions in this instance
  int failures = 0;

  // ----------------------------------------------------------------------
  // output strobe shape
  // ----------------------------------------------------------------------

  // one output per group, never two cycles in a row
  single_cycle_strobe: assert property (
    @(posedge clock) disable iff (rst) out_strobe |=> !out_strobe
  ) else
  begin
    $error("output strobe held for more than one cycle");
    failures++;
  end

  // the register is cleared by the first reset edge
  quiet_in_reset: assert property (
    @(posedge clock) rst |=> !out_strobe
  ) else
  begin
    $error("output strobe seen while reset was high");
    failures++;
  end

  // decision cycle plus comb and round register
  fixed_latency: assert property (
    @(posedge clock) disable iff (rst) out_strobe |-> $past(in_strobe, 2)
  ) else
  begin
    $error("output strobe without an input strobe two cycles before");
    failures++;
  end

endmodule

// File: verif/rx_ddc_monitor.sv
`timescale 1ns/100ps
`include "rx_cfg.svh"

module rx_ddc_monitor (
  input logic                clock,
  input logic                rst,
  input logic                adc_strobe,
  input rx_pkg::adc_sample_t adc_data,
  input rx_pkg::phase_t      tune_word,
  input logic                tune_load,
  input logic                out_strobe,
  input logic                out_frame,
  input rx_pkg::out_sample_t out_i,
  input rx_pkg::out_sample_t out_q
);
  import rx_pkg::*;

  localparam int ST    = `RX_CIC_STAGES;
  localparam int D1    = `RX_CIC1_DECIM;
  localparam int D2    = `RX_CIC2_DECIM;
  localparam int ACC1  = `RX_MIX_WIDTH + $clog2(D1 ** ST);
  localparam int ACC2  = `RX_CIC1_OUT_WIDTH + $clog2(D2 ** ST);
  localparam int NTAB  = 1 << `RX_TABLE_BITS;
  localparam int SHIFT = `RX_ADC_WIDTH + `RX_LO_WIDTH - `RX_MIX_WIDTH;

  int          cos_tab [NTAB];
  longint      integ [2][2][ST];
  longint      dly   [2][2][ST];
  int          cnt   [2];
  bit          gframe[2];
  phase_t      phase;
  phase_t      tune;
  bit          pend;
  out_sample_t q_i[$];
  out_sample_t q_q[$];
  bit          q_f[$];
  int          errors;
  int          out_count;
  int          model_count;
  int          frame_count;
  int          pending;

  // ----------------------------------------------------------------------
  // reference model of the chain
  // ----------------------------------------------------------------------

  // sign extend the low w bits
  function automatic longint wrap(longint v, int w);
    return (v <<< (64 - w)) >>> (64 - w);
  endfunction

  task automatic clear_model();
    for (int d = 0; d < 2; d++)
    begin
      cnt[d] = 0;
      gframe[d] = 0;
      for (int c = 0; c < 2; c++)
        for (int s = 0; s < ST; s++)
        begin
          integ[d][c][s] = 0;
          dly[d][c][s] = 0;
        end
    end
    phase = '0;
    tune = '0;
    pend = 0;
  endtask

  // one input sample into decimator d, done marks an output
  task automatic cic_step(input int d, input longint xi, input longint xq, input bit fr,
                          output bit done, output longint yi, output longint yq,
                          output bit yf);
    longint x [2];
    longint y [2];
    longint c;
    longint nxt;
    longint r;
    int     aw;
    int     ow;
    int     eff;
    begin
      x[0] = xi;
      x[1] = xq;
      aw = (d == 0) ? ACC1 : ACC2;
      ow = (d == 0) ? `RX_CIC1_OUT_WIDTH : `RX_OUT_WIDTH;
      eff = fr ? 0 : cnt[d];
      // pipelined integrators, later stages see the old value
      for (int ch = 0; ch < 2; ch++)
      begin
        for (int s = ST - 1; s > 0; s--)
          integ[d][ch][s] = wrap(integ[d][ch][s] + integ[d][ch][s-1], aw);
        integ[d][ch][0] = wrap(integ[d][ch][0] + x[ch], aw);
      end
      done = (eff == ((d == 0) ? D1 : D2) - 1);
      yf = (eff == 0) ? fr : gframe[d];
      if (eff == 0)
        gframe[d] = fr;
      cnt[d] = done ? 0 : eff + 1;
      y[0] = 0;
      y[1] = 0;
      if (done)
        for (int ch = 0; ch < 2; ch++)
        begin
          c = integ[d][ch][ST-1];
          for (int s = 0; s < ST; s++)
          begin
            nxt = wrap(c - dly[d][ch][s], aw);
            dly[d][ch][s] = c;
            c = nxt;
          end
          // keep top ow bits, add the bit below them
          r = (c >>> (aw - ow)) + ((c >>> (aw - ow - 1)) & 1);
          y[ch] = wrap(r, ow);
        end
      yi = y[0];
      yq = y[1];
    end
  endtask

  task automatic model_sample(input int a);
    int     addr;
    longint mi;
    longint mq;
    longint m2i;
    longint m2q;
    longint oi;
    longint oq;
    bit     d1;
    bit     d2;
    bit     f1;
    bit     f2;
    begin
      addr = phase[`RX_PHASE_WIDTH-1 -: `RX_TABLE_BITS];
      // sine sits a quarter cycle behind cosine
      mi = (a * cos_tab[addr]) >>> SHIFT;
      mq = (-(a * cos_tab[(addr - NTAB / 4) & (NTAB - 1)])) >>> SHIFT;
      cic_step(0, mi, mq, pend, d1, m2i, m2q, f1);
      if (d1)
      begin
        cic_step(1, m2i, m2q, f1, d2, oi, oq, f2);
        if (d2)
        begin
          q_i.push_back(out_sample_t'(oi));
          q_q.push_back(out_sample_t'(oq));
          q_f.push_back(f2);
          model_count++;
        end
      end
    end
  endtask

  initial
  begin
    real v;
    errors = 0;
    out_count = 0;
    model_count = 0;
    frame_count = 0;
    for (int k = 0; k < NTAB; k++)
    begin
      v = $cos(2.0 * 3.14159265358979 * k / NTAB) * 2047.0;
      cos_tab[k] = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
    end
    clear_model();
  end

  // ----------------------------------------------------------------------
  // compare, then advance the model
  // ----------------------------------------------------------------------

  logic rst_q = 1'b0;

  always @(posedge clock)
  begin
    if (out_strobe)
    begin
      out_count++;
      frame_count += out_frame;
      if (rst && rst_q)
      begin
        $display("output strobe appeared while reset was held");
        errors++;
      end
      if (q_i.size() == 0)
      begin
        $display("output strobe arrived with no expected sample left");
        errors++;
      end
      else
      begin
        if (out_i !== q_i[0])
        begin
          $display("[ERROR] out_i got %h expected %h", out_i, q_i[0]);
          errors++;
        end
        if (out_q !== q_q[0])
        begin
          $display("[ERROR] out_q got %h expected %h", out_q, q_q[0]);
          errors++;
        end
        if (out_frame !== q_f[0])
        begin
          $display("[ERROR] out_frame got %h expected %h", out_frame, q_f[0]);
          errors++;
        end
        void'(q_i.pop_front());
        void'(q_q.pop_front());
        void'(q_f.pop_front());
      end
    end
    if (rst)
    begin
      // samples still in flight are lost in the DUT too
      model_count -= q_i.size();
      q_i.delete();
      q_q.delete();
      q_f.delete();
      clear_model();
    end
    else
    begin
      if (adc_strobe)
        model_sample(int'(adc_data));
      if (tune_load)
      begin
        phase = '0;
        tune = tune_word;
        pend = 1;
      end
      else if (adc_strobe)
      begin
        phase = phase + tune;
        pend = 0;
      end
    end
    rst_q <= rst;
    pending = q_i.size();
  end

endmodule

// File: verif/tb_rx_ddc.sv
`timescale 1ns/100ps

module tb_rx_ddc;
  import rx_pkg::*;

  // sum of the strobes sent by all tests
  localparam int     TOTAL_STROBES = 3436;
  localparam longint WATCHDOG_NS   = longint'(TOTAL_STROBES) * 8 * 8 * 2;

  logic        clock;
  logic        rst;
  logic        adc_strobe;
  logic        tune_load;
  adc_sample_t adc_data;
  phase_t      tune_word;
  logic        out_strobe;
  logic        out_frame;
  out_sample_t out_i;
  out_sample_t out_q;
  logic [31:0] lcg_state;
  int          pass_count;
  int          fail_count;
  int          base_out;
  int          base_model;
  int          base_err;
  int          base_frame;
  int          base_assert;

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  rx_ddc u_rx_ddc (
    .clock(clock), .rst(rst), .adc_strobe(adc_strobe), .tune_load(tune_load),
    .adc_data(adc_data), .tune_word(tune_word), .out_strobe(out_strobe),
    .out_frame(out_frame), .out_i(out_i), .out_q(out_q)
  );

  rx_ddc_monitor u_monitor (
    .clock(clock), .rst(rst), .adc_strobe(adc_strobe), .adc_data(adc_data),
    .tune_word(tune_word), .tune_load(tune_load), .out_strobe(out_strobe),
    .out_frame(out_frame), .out_i(out_i), .out_q(out_q)
  );

  bind cic_decimator rx_ddc_properties u_props (
    .clock(clock), .rst(rst), .in_strobe(in_s.strobe), .out_strobe(out_s.strobe)
  );

  // failed concurrent assertions in both decimators
  function automatic int assertion_failures();
    return u_rx_ddc.u_cic1.u_props.failures + u_rx_ddc.u_cic2.u_props.failures;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus tasks
  // ----------------------------------------------------------------------

  task automatic hold_reset();
    @(posedge clock);
    #1 rst = 1'b1;
    adc_strobe = 1'b0;
    tune_load = 1'b0;
    repeat (8) @(posedge clock);
    #1 rst = 1'b0;
  endtask

  task automatic load_tune(input phase_t w);
    @(posedge clock);
    #1 tune_load = 1'b1;
    tune_word = w;
    adc_strobe = 1'b0;
    @(posedge clock);
    #1 tune_load = 1'b0;
  endtask

  // gap_pct is the chance in percent of an idle cycle
  task automatic send_samples(input int n, input bit dc, input int dc_value,
                              input int gap_pct);
    int          sent = 0;
    logic [31:0] r;
    while (sent < n)
    begin
      @(posedge clock);
      #1 r = lcg_next();
      adc_strobe = (r % 100) >= gap_pct;
      adc_data = dc ? adc_sample_t'(dc_value) : adc_sample_t'(r[31:20]);
      if (adc_strobe)
        sent++;
    end
    @(posedge clock);
    #1 adc_strobe = 1'b0;
  endtask

  task automatic drain();
    while (u_monitor.pending != 0)
    begin
      @(posedge clock);
      #1;
    end
    repeat (8) @(posedge clock);
    #1;
  endtask

  task automatic start_test();
    base_out = u_monitor.out_count;
    base_model = u_monitor.model_count;
    base_err = u_monitor.errors;
    base_frame = u_monitor.frame_count;
    base_assert = assertion_failures();
  endtask

  // a negative expectation is not checked
  task automatic finish_test(input string name, input int exp_outs, input int exp_frames);
    int outs;
    int model;
    int errs;
    int frames;
    int asserts;
    bit ok;
    drain();
    outs = u_monitor.out_count - base_out;
    model = u_monitor.model_count - base_model;
    errs = u_monitor.errors - base_err;
    frames = u_monitor.frame_count - base_frame;
    asserts = assertion_failures() - base_assert;
    ok = (errs == 0) && (asserts == 0) && (outs == model);
    ok &= (exp_outs < 0) || (outs == exp_outs);
    ok &= (exp_frames < 0) || (frames == exp_frames);
    $display("test %s: %s, outputs %0d model %0d frames %0d mismatches %0d asserts %0d",
             name, ok ? "ok" : "wrong", outs, model, frames, errs, asserts);
    if (ok)
      pass_count++;
    else
      fail_count++;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial
  begin
    clock = 1'b0;
    rst = 1'b1;
    adc_strobe = 1'b0;
    tune_load = 1'b0;
    adc_data = '0;
    tune_word = '0;
    lcg_state = 32'ha5fd32d6;
    pass_count = 0;
    fail_count = 0;

    hold_reset();
    start_test();
    send_samples(400, 1'b1, 700, 0);
    finish_test("dc_gain", 10, 0);

    hold_reset();
    start_test();
    load_tune(phase_t'(lcg_next()));
    send_samples(800, 1'b0, 0, 0);
    finish_test("random_full_rate", 20, 1);

    hold_reset();
    start_test();
    load_tune(phase_t'(lcg_next()));
    send_samples(800, 1'b0, 0, 40);
    finish_test("random_gapped", 20, 1);

    // partial group before the retune is dropped
    hold_reset();
    start_test();
    load_tune(phase_t'(lcg_next()));
    send_samples(420, 1'b0, 0, 20);
    load_tune(phase_t'(lcg_next()));
    send_samples(400, 1'b0, 0, 20);
    finish_test("retune", 20, 2);

    // strobes keep coming while reset is held
    hold_reset();
    start_test();
    send_samples(200, 1'b0, 0, 0);
    #1 rst = 1'b1;
    send_samples(16, 1'b0, 0, 0);
    rst = 1'b0;
    send_samples(400, 1'b0, 0, 0);
    finish_test("mid_run_reset", -1, 0);

    $display("tests passed %0d failed %0d, mismatches %0d, assertion failures %0d",
             pass_count, fail_count, u_monitor.errors, assertion_failures());
    if (fail_count == 0 && u_monitor.errors == 0 && assertion_failures() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish in the allowed time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+design
design/rx_pkg.sv
design/iq_if.sv
design/nco_mixer.sv
design/cic_decimator.sv
design/rx_ddc.sv
verif/rx_ddc_properties.sv
verif/rx_ddc_monitor.sv
verif/tb_rx_ddc.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rx_ddc -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_rx_ddc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
